// ==== hdl/vic_pkg.sv ====
package vic_pkg;

    // bus access of one phi half
    // l* names a low half, h* names a high half
    typedef enum logic [3:0] {
        // sprite pointer
        lp  = 4'd0,
        // sprite bytes 1 to 3, spread over two cycles
        hs1 = 4'd1,
        ls2 = 4'd2,
        hs3 = 4'd3,
        // dram refresh slot
        lr  = 4'd4,
        // bitmap fetch
        lg  = 4'd5,
        // first c-access of a badline
        hrc = 4'd6,
        // c-access of a badline
        hgc = 4'd7,
        // first buffer replay on a non-badline
        hrx = 4'd8,
        // buffer replay on a non-badline
        hgi = 4'd9,
        // idle halves
        li  = 4'd10,
        hi  = 4'd11
    } vic_cycle_t;

    // hardware sprites
    localparam int num_sprites = 8;

    // character columns, also the line buffer depth
    localparam int num_columns = 40;

    // phi cycles per raster line, two halves each
    localparam int cycles_per_line = 63;

    typedef logic [$clog2(num_sprites)-1:0] sprite_cnt_t;

    // colour in [11:8], character pointer in [7:0]
    typedef logic [11:0] char_t;

endpackage

// ==== hdl/phase_gen.sv ====
module phase_gen #(
    parameter int phase_len = 16,
    parameter int dav_offset = 10
) (
    input  logic rst,
    input  logic clk_dot4x,
    output logic phase_start,
    output logic phase_dav,
    output logic phi_high
);

    localparam int cnt_w = $clog2(phase_len);

    logic [cnt_w-1:0] cnt;
    logic running;
    logic wrap;

    // last dot clock of a phi half
    assign wrap = (cnt == cnt_w'(phase_len - 1));

    // counter holds at 0 for one clock after reset so that the first
    // half also opens with a phase_start pulse
    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            cnt <= '0;
            running <= 1'b0;
            phase_start <= 1'b0;
            phase_dav <= 1'b0;
            phi_high <= 1'b0;
        end else begin
            running <= 1'b1;
            // strobes are high while cnt sits at 0 and at dav_offset
            phase_start <= !running || wrap;
            phase_dav <= (cnt == cnt_w'(dav_offset - 1));
            if (running) begin
                if (wrap) begin
                    cnt <= '0;
                    phi_high <= !phi_high;
                end else begin
                    cnt <= cnt + 1'b1;
                end
            end
        end
    end

endmodule

// ==== hdl/cycle_sequencer.sv ====
module cycle_sequencer (
    input  logic rst,
    input  logic clk_dot4x,
    input  logic phase_start,
    input  logic phi_high,
    input  logic badline,
    input  logic [vic_pkg::num_sprites-1:0] sprite_dma,
    output vic_pkg::vic_cycle_t cycle_type,
    output vic_pkg::sprite_cnt_t sprite_cnt,
    output logic aec,
    output logic line_start
);

    import vic_pkg::*;

    localparam int cyc_w = $clog2(cycles_per_line);
    // two cycles per sprite at the start of the line
    localparam int spr_end = 2 * num_sprites;
    // four refresh cycles, then the c-access window
    localparam int c_first = spr_end + 4;
    localparam int c_last = c_first + num_columns - 1;

    logic [cyc_w-1:0] cycle;
    logic [cyc_w-1:0] next_cycle;
    logic running;
    logic bl_line;
    logic [num_sprites-1:0] dma_line;
    logic first_c;
    vic_cycle_t next_type;
    sprite_cnt_t next_spr;
    logic next_aec;

    // phi_high already shows the half that this phase_start opens
    always_comb begin
        next_cycle = cycle;
        if (running && !phi_high) begin
            if (cycle == cyc_w'(cycles_per_line - 1)) begin
                next_cycle = '0;
            end else begin
                next_cycle = cycle + 1'b1;
            end
        end
    end

    assign first_c = (next_cycle == cyc_w'(c_first));

    // line layout decode
    always_comb begin
        next_type = li;
        next_spr = '0;
        next_aec = phi_high;
        if (next_cycle < cyc_w'(spr_end)) begin
            next_spr = next_cycle[$clog2(num_sprites):1];
            if (phi_high) begin
                next_type = next_cycle[0] ? hs3 : hs1;
                next_aec = !dma_line[next_spr];
            end else begin
                next_type = next_cycle[0] ? ls2 : lp;
            end
        end else if (next_cycle < cyc_w'(c_first)) begin
            next_type = phi_high ? hi : lr;
        end else if (next_cycle <= cyc_w'(c_last)) begin
            if (!phi_high) begin
                next_type = first_c ? lr : lg;
            end else if (bl_line) begin
                next_type = first_c ? hrc : hgc;
            end else begin
                next_type = first_c ? hrx : hgi;
            end
        end else if (next_cycle == cyc_w'(c_last + 1)) begin
            // last g-access follows the last c-access
            next_type = phi_high ? hi : lg;
        end else begin
            next_type = phi_high ? hi : li;
        end
        // badline c-access takes the bus
        if (next_type == hrc || next_type == hgc) begin
            next_aec = 1'b0;
        end
    end

    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            cycle <= '0;
            running <= 1'b0;
            cycle_type <= li;
            sprite_cnt <= '0;
            aec <= 1'b1;
            line_start <= 1'b0;
            bl_line <= 1'b0;
            dma_line <= '0;
        end else begin
            line_start <= 1'b0;
            // line settings are taken during cycle 0 low half
            if (line_start) begin
                bl_line <= badline;
                dma_line <= sprite_dma;
            end
            if (phase_start) begin
                running <= 1'b1;
                cycle <= next_cycle;
                cycle_type <= next_type;
                sprite_cnt <= next_spr;
                aec <= next_aec;
                line_start <= (next_cycle == '0) && !phi_high;
            end
        end
    end

endmodule

// ==== hdl/bus_access.sv ====
module bus_access (
    input  logic rst,
    input  logic clk_dot4x,
    input  logic phase_dav,
    input  vic_pkg::vic_cycle_t cycle_type,
    input  vic_pkg::char_t dbi,
    input  logic idle,
    input  vic_pkg::sprite_cnt_t sprite_cnt,
    input  logic aec,
    input  logic [vic_pkg::num_sprites-1:0] sprite_dma,
    output logic [8*vic_pkg::num_sprites-1:0] sprite_ptr,
    output logic [24*vic_pkg::num_sprites-1:0] sprite_pixels,
    output logic [7:0] pixels_read,
    output vic_pkg::char_t char_read,
    output vic_pkg::char_t char_next
);

    import vic_pkg::*;

    localparam int col_w = $clog2(num_columns);

    // character line buffer, filled on badlines
    char_t char_buf [num_columns];
    logic [col_w-1:0] col;
    logic [7:0] ptr_r [num_sprites];
    logic [23:0] pix_r [num_sprites];
    logic c_fill;
    logic c_replay;
    logic low_half;
    logic s_fetch;
    char_t c_word;

    assign c_fill = (cycle_type == hrc) || (cycle_type == hgc);
    assign c_replay = (cycle_type == hrx) || (cycle_type == hgi);
    assign low_half = cycle_type inside {lp, ls2, lr, lg, li};
    assign s_fetch = cycle_type inside {hs1, ls2, hs3};

    // colour is always read, pointer reads ff without the bus
    assign c_word = {dbi[11:8], (aec ? 8'hff : dbi[7:0])};

    // sprite 0 in the top byte
    for (genvar n = 0; n < num_sprites; n++) begin : g_pack
        assign sprite_ptr[8*(num_sprites-1-n) +: 8] = ptr_r[n];
        assign sprite_pixels[24*(num_sprites-1-n) +: 24] = pix_r[n];
    end

    always_ff @(posedge clk_dot4x) begin
        if (phase_dav && c_fill) begin
            char_buf[col] <= c_word;
        end
    end

    // c-access, live on badlines and replayed from the buffer otherwise
    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            col <= '0;
            char_next <= '0;
        end else if (phase_dav) begin
            if (c_fill) begin
                char_next <= c_word;
            end else if (c_replay) begin
                char_next <= char_buf[col];
            end
            if (c_fill || c_replay) begin
                col <= (col == col_w'(num_columns - 1)) ? '0 : col + 1'b1;
            end
        end
    end

    // g-access
    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            pixels_read <= '0;
            char_read <= '0;
        end else if (phase_dav && !aec) begin
            if (cycle_type == lg) begin
                pixels_read <= dbi[7:0];
                char_read <= idle ? '0 : char_next;
            end else if (low_half) begin
                pixels_read <= '0;
            end
        end
    end

    // p-access
    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            for (int n = 0; n < num_sprites; n++) begin
                ptr_r[n] <= '0;
            end
        end else if (phase_dav && cycle_type == lp) begin
            ptr_r[sprite_cnt] <= sprite_dma[sprite_cnt] ? dbi[7:0] : 8'hff;
        end
    end

    // s-access, three bytes shifted in from the right
    always_ff @(posedge clk_dot4x) begin
        if (phase_dav && !aec && s_fetch && sprite_dma[sprite_cnt]) begin
            pix_r[sprite_cnt] <= {pix_r[sprite_cnt][15:0], dbi[7:0]};
        end
    end

endmodule

// ==== hdl/vic_fetch_top.sv ====
module vic_fetch_top #(
    parameter int phase_len = 16,
    parameter int dav_offset = 10
) (
    input  logic rst,
    input  logic clk_dot4x,
    input  vic_pkg::char_t dbi,
    input  logic badline,
    input  logic idle,
    input  logic [vic_pkg::num_sprites-1:0] sprite_dma,
    output vic_pkg::vic_cycle_t cycle_type,
    output vic_pkg::sprite_cnt_t sprite_cnt,
    output logic aec,
    output logic phase_dav,
    output logic line_start,
    output logic [8*vic_pkg::num_sprites-1:0] sprite_ptr,
    output logic [24*vic_pkg::num_sprites-1:0] sprite_pixels,
    output logic [7:0] pixels_read,
    output vic_pkg::char_t char_read,
    output vic_pkg::char_t char_next
);

    logic phase_start;
    logic phi_high;

    phase_gen #(
        .phase_len (phase_len),
        .dav_offset(dav_offset)
    ) phase_gen_i (
        .rst        (rst),
        .clk_dot4x  (clk_dot4x),
        .phase_start(phase_start),
        .phase_dav  (phase_dav),
        .phi_high   (phi_high)
    );

    cycle_sequencer cycle_sequencer_i (
        .rst        (rst),
        .clk_dot4x  (clk_dot4x),
        .phase_start(phase_start),
        .phi_high   (phi_high),
        .badline    (badline),
        .sprite_dma (sprite_dma),
        .cycle_type (cycle_type),
        .sprite_cnt (sprite_cnt),
        .aec        (aec),
        .line_start (line_start)
    );

    bus_access bus_access_i (
        .rst          (rst),
        .clk_dot4x    (clk_dot4x),
        .phase_dav    (phase_dav),
        .cycle_type   (cycle_type),
        .dbi          (dbi),
        .idle         (idle),
        .sprite_cnt   (sprite_cnt),
        .aec          (aec),
        .sprite_dma   (sprite_dma),
        .sprite_ptr   (sprite_ptr),
        .sprite_pixels(sprite_pixels),
        .pixels_read  (pixels_read),
        .char_read    (char_read),
        .char_next    (char_next)
    );

endmodule

// ==== verification/vic_fetch_chk.sv ====
module vic_fetch_chk (
    input logic rst,
    input logic clk_dot4x,
    input logic phase_start,
    input logic phase_dav,
    input vic_pkg::vic_cycle_t cycle_type,
    input vic_pkg::sprite_cnt_t sprite_cnt,
    input logic aec
);
    timeunit 1ns;
    timeprecision 100ps;

    import vic_pkg::*;

    logic armed;

    // outputs hold their reset values until the first half opens
    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            armed <= 1'b0;
        end else if (phase_start) begin
            armed <= 1'b1;
        end
    end

    a_dav_apart: assert property (@(posedge clk_dot4x) disable iff (rst)
        !(phase_dav && phase_start))
        else $error("phase_dav and phase_start are high in the same clock");

    a_type_step: assert property (@(posedge clk_dot4x) disable iff (rst)
        (cycle_type != $past(cycle_type)) |-> $past(phase_start))
        else $error("cycle_type changed without a phase_start one clock before");

    a_low_aec: assert property (@(posedge clk_dot4x) disable iff (rst)
        (armed && (cycle_type inside {lp, ls2, lr, lg, li})) |-> !aec)
        else $error("aec is high in a low half");

    // one sprite owns all four halves of its two cycles
    a_sprite_slot: assert property (@(posedge clk_dot4x) disable iff (rst)
        (cycle_type inside {hs1, ls2, hs3}) |-> (sprite_cnt == $past(sprite_cnt)))
        else $error("sprite_cnt changed inside a sprite slot");

endmodule

bind vic_fetch_top vic_fetch_chk vic_fetch_chk_i (
    .rst        (rst),
    .clk_dot4x  (clk_dot4x),
    .phase_start(phase_start),
    .phase_dav  (phase_dav),
    .cycle_type (cycle_type),
    .sprite_cnt (sprite_cnt),
    .aec        (aec)
);

// ==== verification/vic_fetch_tb.sv ====
module vic_fetch_tb;
    timeunit 1ns;
    timeprecision 100ps;

    import vic_pkg::*;

    localparam int phase_len = 16;
    localparam int dav_offset = 10;
    localparam int wait_limit = 4 * phase_len;
    localparam int num_rows = 6;
    localparam int first_c = 20;
    localparam int last_c = 59;

    typedef struct packed {
        logic badline;
        logic idle;
        logic [num_sprites-1:0] dma;
        logic [31:0] seed;
    } row_t;

    // one row per raster line, the first must be a badline to fill the buffer
    row_t rows [num_rows] = '{
        '{badline: 1'b1, idle: 1'b0, dma: 8'hff, seed: 32'h0000_0011},
        '{badline: 1'b0, idle: 1'b0, dma: 8'ha5, seed: 32'h0000_2202},
        '{badline: 1'b0, idle: 1'b1, dma: 8'h00, seed: 32'h0003_3033},
        '{badline: 1'b1, idle: 1'b1, dma: 8'h3c, seed: 32'h0044_0404},
        '{badline: 1'b0, idle: 1'b0, dma: 8'h81, seed: 32'h0505_0055},
        '{badline: 1'b1, idle: 1'b0, dma: 8'h5a, seed: 32'h6600_0606}
    };

    logic rst;
    logic clk_dot4x;
    char_t dbi;
    logic badline;
    logic idle;
    logic [num_sprites-1:0] sprite_dma;
    vic_cycle_t cycle_type;
    sprite_cnt_t sprite_cnt;
    logic aec;
    logic phase_dav;
    logic line_start;
    logic [8*num_sprites-1:0] sprite_ptr;
    logic [24*num_sprites-1:0] sprite_pixels;
    logic [7:0] pixels_read;
    char_t char_read;
    char_t char_next;

    // reference model state
    char_t ref_buf [num_columns];
    char_t exp_next;
    char_t exp_read;
    logic [7:0] exp_pixels;
    logic [8*num_sprites-1:0] exp_ptr;
    logic [24*num_sprites-1:0] exp_spr;
    logic [31:0] rnd;

    vic_fetch_top #(
        .phase_len (phase_len),
        .dav_offset(dav_offset)
    ) vic_fetch_top_i (
        .rst          (rst),
        .clk_dot4x    (clk_dot4x),
        .dbi          (dbi),
        .badline      (badline),
        .idle         (idle),
        .sprite_dma   (sprite_dma),
        .cycle_type   (cycle_type),
        .sprite_cnt   (sprite_cnt),
        .aec          (aec),
        .phase_dav    (phase_dav),
        .line_start   (line_start),
        .sprite_ptr   (sprite_ptr),
        .sprite_pixels(sprite_pixels),
        .pixels_read  (pixels_read),
        .char_read    (char_read),
        .char_next    (char_next)
    );

    initial begin
        clk_dot4x = 1'b0;
        forever #10 clk_dot4x = ~clk_dot4x;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // access of a half from the line layout
    function automatic vic_cycle_t expect_type(input int c, input logic high, input logic bl);
        if (c < 2 * num_sprites) begin
            if (high) begin
                return (c % 2 == 1) ? hs3 : hs1;
            end
            return (c % 2 == 1) ? ls2 : lp;
        end
        if (c < first_c) return high ? hi : lr;
        if (c == first_c) return high ? (bl ? hrc : hrx) : lr;
        if (c <= last_c) return high ? (bl ? hgc : hgi) : lg;
        if (c == last_c + 1) return high ? hi : lg;
        return high ? hi : li;
    endfunction

    function automatic logic expect_aec(input vic_cycle_t t, input int c,
                                        input logic [num_sprites-1:0] dma);
        if (t inside {lp, ls2, lr, lg, li, hrc, hgc}) return 1'b0;
        if (t inside {hs1, hs3}) return !dma[c / 2];
        return 1'b1;
    endfunction

    task automatic stop_run();
        $display("sim failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_char(input string name, input char_t got, input char_t exp);
        if (got !== exp) begin
            $display("[FAIL] t=%0t %s got %h expected %h", $time, name, got, exp);
            stop_run();
        end
    endtask

    task automatic check_byte(input string name, input logic [7:0] got,
                              input logic [7:0] exp);
        if (got !== exp) begin
            $display("[FAIL] t=%0t %s got %h expected %h", $time, name, got, exp);
            stop_run();
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("[FAIL] t=%0t %s got %b expected %b", $time, name, got, exp);
            stop_run();
        end
    endtask

    task automatic check_cycle(input vic_cycle_t got, input vic_cycle_t exp);
        if (got !== exp) begin
            $display("[FAIL] t=%0t cycle_type got %s expected %s", $time,
                     got.name(), exp.name());
            stop_run();
        end
    endtask

    task automatic check_sprite_cnt(input sprite_cnt_t got, input sprite_cnt_t exp);
        if (got !== exp) begin
            $display("[FAIL] t=%0t sprite_cnt got %0d expected %0d", $time, got, exp);
            stop_run();
        end
    endtask

    task automatic check_sprite_ptr(input logic [8*num_sprites-1:0] got,
                                    input logic [8*num_sprites-1:0] exp);
        if (got !== exp) begin
            $display("[FAIL] t=%0t sprite_ptr got %h expected %h", $time, got, exp);
            stop_run();
        end
    endtask

    task automatic check_sprite_pixels(input logic [24*num_sprites-1:0] got,
                                       input logic [24*num_sprites-1:0] exp);
        if (got !== exp) begin
            $display("[FAIL] t=%0t sprite_pixels got %h expected %h", $time, got, exp);
            stop_run();
        end
    endtask

    task automatic wait_line_start();
        int n;
        n = 0;
        @(negedge clk_dot4x);
        while (!line_start) begin
            n++;
            if (n > wait_limit) begin
                $display("timeout, no line_start within %0d clocks", wait_limit);
                stop_run();
            end
            @(negedge clk_dot4x);
        end
    endtask

    task automatic wait_type_change(input vic_cycle_t prev);
        int n;
        n = 0;
        @(negedge clk_dot4x);
        while (cycle_type == prev) begin
            n++;
            if (n > wait_limit) begin
                $display("timeout, cycle_type did not move to the next half");
                stop_run();
            end
            @(negedge clk_dot4x);
        end
    endtask

    task automatic wait_dav();
        int n;
        n = 0;
        while (!phase_dav) begin
            n++;
            if (n > wait_limit) begin
                $display("timeout, no phase_dav within %0d clocks", wait_limit);
                stop_run();
            end
            @(negedge clk_dot4x);
        end
    endtask

    // one half of the reference model, applied at the data-valid moment
    task automatic model_half(input vic_cycle_t t, input int c, input row_t row);
        int n;
        int col;
        n = (c / 2) % num_sprites;
        col = c - first_c;
        case (t)
            hrc, hgc: begin
                ref_buf[col] = dbi;
                exp_next = dbi;
            end
            hrx, hgi: exp_next = ref_buf[col];
            lg: begin
                exp_pixels = dbi[7:0];
                exp_read = row.idle ? '0 : exp_next;
            end
            lp: exp_ptr[8*(num_sprites-1-n) +: 8] = row.dma[n] ? dbi[7:0] : 8'hff;
            default: ;
        endcase
        if ((t inside {hs1, ls2, hs3}) && row.dma[n]) begin
            exp_spr[24*(num_sprites-1-n) +: 24] =
                {exp_spr[24*(num_sprites-1-n) +: 16], dbi[7:0]};
        end
        if (t inside {lp, ls2, lr, li}) begin
            exp_pixels = '0;
        end
    endtask

    initial begin
        int c;
        logic high;
        vic_cycle_t etype;
        vic_cycle_t prev;
        rst = 1'b1;
        dbi = '0;
        badline = 1'b0;
        idle = 1'b0;
        sprite_dma = '0;
        exp_next = '0;
        exp_read = '0;
        exp_pixels = '0;
        exp_ptr = '0;
        exp_spr = '0;
        prev = li;
        repeat (8) @(negedge clk_dot4x);
        rst = 1'b0;
        for (int r = 0; r < num_rows; r++) begin
            wait_line_start();
            badline = rows[r].badline;
            idle = rows[r].idle;
            sprite_dma = rows[r].dma;
            rnd = 32'd6673 ^ rows[r].seed;
            for (int h = 0; h < 2 * cycles_per_line; h++) begin
                c = h / 2;
                high = (h % 2) == 1;
                if (h > 0) begin
                    wait_type_change(prev);
                end
                etype = expect_type(c, high, rows[r].badline);
                check_cycle(cycle_type, etype);
                check_bit("aec", aec, expect_aec(etype, c, rows[r].dma));
                // sprite n owns cycles 2n and 2n+1
                if (c < 2 * num_sprites) begin
                    check_sprite_cnt(sprite_cnt, sprite_cnt_t'(c / 2));
                end
                prev = cycle_type;
                rnd = xorshift(rnd);
                dbi = rnd[11:0];
                wait_dav();
                model_half(etype, c, rows[r]);
                @(negedge clk_dot4x);
                check_char("char_next", char_next, exp_next);
                check_char("char_read", char_read, exp_read);
                check_byte("pixels_read", pixels_read, exp_pixels);
                check_sprite_ptr(sprite_ptr, exp_ptr);
                // sprite registers are unknown until the first line fills them
                if (r > 0) begin
                    check_sprite_pixels(sprite_pixels, exp_spr);
                end
            end
        end
        $display("sim passed");
        $finish;
    end

endmodule

// ==== list.f ====
hdl/vic_pkg.sv
hdl/phase_gen.sv
hdl/cycle_sequencer.sv
hdl/bus_access.sv
hdl/vic_fetch_top.sv
verification/vic_fetch_chk.sv
verification/vic_fetch_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module vic_fetch_tb -f list.f -o vic_fetch_sim \
    && ./obj_dir/vic_fetch_sim | tee sim.log \
    && grep -q "^sim passed$" sim.log \
    && echo "simulation passed" \
    || { echo "simulation did not pass"; exit 1; }
